//--- l1d_pkg.sv
/*
 * Shared constants and types for the L1 data cache.
 * Address split is fixed: tag [31:6], index [5:2], byte offset [1:0].
 * One 32-bit word per line, so lower-level addresses always carry
 * a zero offset.
 * No snooping, hence no shared state. A line is I, E or M only.
 */

package l1d_pkg;

    // ======================================================================
    // geometry
    // ======================================================================
    localparam int addr_wid   = 32;
    localparam int data_wid   = 32;

    localparam int num_ways   = 4;
    localparam int way_wid    = 2;

    localparam int num_sets   = 16;
    localparam int index_wid  = 4;

    localparam int offset_wid = 2;
    localparam int tag_wid    = addr_wid - index_wid - offset_wid;

    // ======================================================================
    // types
    // ======================================================================

    // two-bit MESI codes without the shared one
    typedef enum logic [1:0] {
        LINE_I = 2'b00,
        LINE_E = 2'b10,
        LINE_M = 2'b11
    } line_state_e;

    typedef enum logic [2:0] {
        CTRL_IDLE = 3'd0,
        CTRL_HIT  = 3'd1,
        CTRL_WB   = 3'd2,
        CTRL_FILL = 3'd3,
        CTRL_DONE = 3'd4
    } ctrl_state_e;

endpackage

//--- l1d_lookup.sv
/*
 * Lookup stage. Registers one CPU request and holds the tag and
 * line-state arrays. Hit and way results for the registered request
 * are combinational in the cycle after capture.
 * A strobe is only legal while busy is low. The request registers
 * hold their value until the next accepted strobe.
 */

`timescale 1ns/1ps

module l1d_lookup import l1d_pkg::*; (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                cpu_rd,
    input  logic                                cpu_wr,
    input  logic [addr_wid-1:0]                 cpu_addr,
    input  logic [data_wid-1:0]                 cpu_wdata,
    input  logic                                busy,
    input  logic                                tag_we,
    input  logic [way_wid-1:0]                  tag_we_way,
    input  line_state_e                         tag_we_state,
    output logic                                req_valid,
    output logic                                req_is_wr,
    output logic [index_wid-1:0]                req_index,
    output logic [tag_wid-1:0]                  req_tag,
    output logic [data_wid-1:0]                 req_wdata,
    output logic                                hit,
    output logic [way_wid-1:0]                  hit_way,
    output line_state_e [num_ways-1:0]          way_states,
    output logic [num_ways-1:0][tag_wid-1:0]    way_tags
);

    logic [tag_wid-1:0] tag_mem    [num_sets][num_ways];
    line_state_e        line_state [num_sets][num_ways];
    logic               accept;

    assign accept = (cpu_rd || cpu_wr) && !busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= accept;
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_is_wr <= cpu_wr;
            req_index <= cpu_addr[offset_wid +: index_wid];
            req_tag   <= cpu_addr[addr_wid-1 -: tag_wid];
            req_wdata <= cpu_wdata;
        end
    end

    // ======================================================================
    // tag and state arrays
    // ======================================================================
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[req_index][tag_we_way] <= req_tag;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    line_state[s][w] <= LINE_I;
                end
            end
        end else if (tag_we) begin
            line_state[req_index][tag_we_way] <= tag_we_state;
        end
    end

    // compare all ways of the captured set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            way_states[w] = line_state[req_index][w];
            way_tags[w]   = tag_mem[req_index][w];
            if (line_state[req_index][w] != LINE_I && tag_mem[req_index][w] == req_tag) begin
                hit     = 1'b1;
                hit_way = way_wid'(w);
            end
        end
    end

    // cpu must wait for the controller to finish the previous access
    a_no_strobe_while_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        (cpu_rd || cpu_wr) |-> !busy
    );

endmodule

//--- l1d_lru.sv
/*
 * True LRU for four ways per set, kept as a 2-bit age per way.
 * Ages in a set always form a permutation of 0..3, oldest is 3.
 * After reset each way's age equals its way number.
 */

`timescale 1ns/1ps

module l1d_lru import l1d_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [index_wid-1:0] index,
    input  logic                 touch,
    input  logic [way_wid-1:0]   touch_way,
    output logic [way_wid-1:0]   lru_way
);

    logic [way_wid-1:0] ages [num_sets][num_ways];
    logic [way_wid-1:0] touch_age;

    assign touch_age = ages[index][touch_way];

    // touched way becomes youngest, younger ways move up by one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    ages[s][w] <= way_wid'(w);
                end
            end
        end else if (touch) begin
            for (int w = 0; w < num_ways; w++) begin
                if (way_wid'(w) == touch_way) begin
                    ages[index][w] <= '0;
                end else if (ages[index][w] < touch_age) begin
                    ages[index][w] <= ages[index][w] + 1'b1;
                end
            end
        end
    end

    // oldest way of the addressed set
    always_comb begin
        lru_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (ages[index][w] == way_wid'(num_ways - 1)) begin
                lru_way = way_wid'(w);
            end
        end
    end

endmodule

//--- l1d_data_array.sv
/*
 * Data word storage, one word per set and way.
 * Read is asynchronous, write happens on the clock edge.
 * Contents are undefined until a line is refilled.
 */

`timescale 1ns/1ps

module l1d_data_array import l1d_pkg::*; (
    input  logic                 clk,
    input  logic [index_wid-1:0] index,
    input  logic [way_wid-1:0]   way,
    input  logic                 we,
    input  logic [data_wid-1:0]  wdata,
    output logic [data_wid-1:0]  rdata
);

    logic [data_wid-1:0] mem [num_sets][num_ways];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index][way] <= wdata;
        end
    end

    assign rdata = mem[index][way];

endmodule

//--- l1d_ctrl.sv
/*
 * Control stage FSM. Decides one cycle after the request is captured.
 * Hit: done pulse two edges after the strobe.
 * Miss: write back the victim if dirty, refill, then finish like a hit.
 * Lower-level levels stay high until the matching done or valid pulse,
 * with address and data held stable. Latency there is the only stall.
 */

`timescale 1ns/1ps

module l1d_ctrl import l1d_pkg::*; (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                req_valid,
    input  logic                                req_is_wr,
    input  logic [index_wid-1:0]                req_index,
    input  logic [tag_wid-1:0]                  req_tag,
    input  logic [data_wid-1:0]                 req_wdata,
    input  logic                                hit,
    input  logic [way_wid-1:0]                  hit_way,
    input  line_state_e [num_ways-1:0]          way_states,
    input  logic [num_ways-1:0][tag_wid-1:0]    way_tags,
    input  logic [way_wid-1:0]                  lru_way,
    input  logic [data_wid-1:0]                 data_rdata,
    input  logic                                lv2_rd_valid,
    input  logic [data_wid-1:0]                 lv2_rd_data,
    input  logic                                lv2_wr_done,
    output logic                                busy,
    output logic                                rd_valid,
    output logic [data_wid-1:0]                 rd_data,
    output logic                                wr_done,
    output logic                                tag_we,
    output logic [way_wid-1:0]                  tag_we_way,
    output line_state_e                         tag_we_state,
    output logic                                lru_touch,
    output logic [way_wid-1:0]                  lru_touch_way,
    output logic [way_wid-1:0]                  data_way,
    output logic                                data_we,
    output logic [data_wid-1:0]                 data_wdata,
    output logic                                lv2_rd,
    output logic                                lv2_wr,
    output logic [addr_wid-1:0]                 lv2_addr,
    output logic [data_wid-1:0]                 lv2_wr_data
);

    ctrl_state_e        state;
    logic [way_wid-1:0] acc_way;
    logic [way_wid-1:0] victim_way;
    logic               victim_dirty;
    logic               miss_start;
    logic               wb_end;
    logic               fill_end;
    logic               complete;
    logic [addr_wid-1:0] fill_addr;

    // lowest invalid way first, otherwise the LRU way
    always_comb begin
        victim_way = lru_way;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (way_states[w] == LINE_I) begin
                victim_way = way_wid'(w);
            end
        end
    end

    assign victim_dirty = (way_states[victim_way] == LINE_M);
    assign miss_start   = (state == CTRL_IDLE) && req_valid && !hit;
    assign wb_end       = (state == CTRL_WB) && lv2_wr_done;
    assign fill_end     = (state == CTRL_FILL) && lv2_rd_valid;
    // DONE finishes a miss after refill, HIT finishes a plain hit
    assign complete     = (state == CTRL_HIT) || (state == CTRL_DONE);
    assign fill_addr    = {req_tag, req_index, {offset_wid{1'b0}}};

    // ======================================================================
    // FSM and strobes
    // ======================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= CTRL_IDLE;
            rd_valid <= 1'b0;
            wr_done  <= 1'b0;
            lv2_rd   <= 1'b0;
            lv2_wr   <= 1'b0;
        end else begin
            rd_valid <= complete && !req_is_wr;
            wr_done  <= complete && req_is_wr;
            case (state)
                CTRL_IDLE: begin
                    if (req_valid && hit) begin
                        state <= CTRL_HIT;
                    end else if (miss_start && victim_dirty) begin
                        state  <= CTRL_WB;
                        lv2_wr <= 1'b1;
                    end else if (miss_start) begin
                        state  <= CTRL_FILL;
                        lv2_rd <= 1'b1;
                    end
                end
                CTRL_WB: begin
                    if (wb_end) begin
                        state  <= CTRL_FILL;
                        lv2_wr <= 1'b0;
                        lv2_rd <= 1'b1;
                    end
                end
                CTRL_FILL: begin
                    if (fill_end) begin
                        state  <= CTRL_DONE;
                        lv2_rd <= 1'b0;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (state == CTRL_IDLE && req_valid) begin
            acc_way <= hit ? hit_way : victim_way;
        end
        if (miss_start) begin
            lv2_wr_data <= data_rdata;
            lv2_addr    <= victim_dirty ? {way_tags[victim_way], req_index, {offset_wid{1'b0}}}
                                        : fill_addr;
        end else if (wb_end) begin
            lv2_addr <= fill_addr;
        end
        if (complete && !req_is_wr) begin
            rd_data <= data_rdata;
        end
    end

    // array, tag and LRU updates
    assign busy          = req_valid || (state != CTRL_IDLE);
    assign data_way      = (state == CTRL_IDLE) ? victim_way : acc_way;
    assign data_we       = fill_end || (complete && req_is_wr);
    assign data_wdata    = fill_end ? lv2_rd_data : req_wdata;
    assign tag_we        = data_we;
    assign tag_we_way    = acc_way;
    assign tag_we_state  = req_is_wr ? LINE_M : LINE_E;
    assign lru_touch     = complete;
    assign lru_touch_way = acc_way;

    a_lv2_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(lv2_rd && lv2_wr)
    );

    a_busy_ends_with_done: assert property (
        @(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> (rd_valid || wr_done)
    );

endmodule

//--- l1d_top.sv
/*
 * L1 data cache top, 4-way, 16 sets, one word per line.
 * Single core, no snooping, write-allocate with write-back.
 * One request at a time: the CPU waits for busy to fall.
 */

`timescale 1ns/1ps

module l1d_top import l1d_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                cpu_rd,
    input  logic                cpu_wr,
    input  logic [addr_wid-1:0] cpu_addr,
    input  logic [data_wid-1:0] cpu_wdata,
    output logic                busy,
    output logic                rd_valid,
    output logic [data_wid-1:0] rd_data,
    output logic                wr_done,
    output logic                lv2_rd,
    output logic                lv2_wr,
    output logic [addr_wid-1:0] lv2_addr,
    output logic [data_wid-1:0] lv2_wr_data,
    input  logic                lv2_rd_valid,
    input  logic [data_wid-1:0] lv2_rd_data,
    input  logic                lv2_wr_done
);

    logic                             req_valid;
    logic                             req_is_wr;
    logic [index_wid-1:0]             req_index;
    logic [tag_wid-1:0]               req_tag;
    logic [data_wid-1:0]              req_wdata;
    logic                             hit;
    logic [way_wid-1:0]               hit_way;
    line_state_e [num_ways-1:0]       way_states;
    logic [num_ways-1:0][tag_wid-1:0] way_tags;
    logic                             tag_we;
    logic [way_wid-1:0]               tag_we_way;
    line_state_e                      tag_we_state;
    logic                             lru_touch;
    logic [way_wid-1:0]               lru_touch_way;
    logic [way_wid-1:0]               lru_way;
    logic [way_wid-1:0]               data_way;
    logic                             data_we;
    logic [data_wid-1:0]              data_wdata;
    logic [data_wid-1:0]              data_rdata;

    l1d_lookup i_l1d_lookup (
        .clk, .arst_n, .cpu_rd, .cpu_wr, .cpu_addr, .cpu_wdata,
        .busy, .tag_we, .tag_we_way, .tag_we_state,
        .req_valid, .req_is_wr, .req_index, .req_tag, .req_wdata,
        .hit, .hit_way, .way_states, .way_tags
    );

    l1d_ctrl i_l1d_ctrl (
        .clk, .arst_n, .req_valid, .req_is_wr, .req_index, .req_tag, .req_wdata,
        .hit, .hit_way, .way_states, .way_tags, .lru_way, .data_rdata,
        .lv2_rd_valid, .lv2_rd_data, .lv2_wr_done,
        .busy, .rd_valid, .rd_data, .wr_done, .tag_we, .tag_we_way, .tag_we_state,
        .lru_touch, .lru_touch_way, .data_way, .data_we, .data_wdata,
        .lv2_rd, .lv2_wr, .lv2_addr, .lv2_wr_data
    );

    // req_index fans out to both side arrays
    l1d_lru i_l1d_lru (
        .clk, .arst_n,
        .index     (req_index),
        .touch     (lru_touch),
        .touch_way (lru_touch_way),
        .lru_way
    );

    l1d_data_array i_l1d_data_array (
        .clk,
        .index (req_index),
        .way   (data_way),
        .we    (data_we),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

endmodule

//--- tb_l1d_mem.sv
/*
 * Lower-level memory model for the L1 data cache testbench.
 * Answers a held lv2_rd or lv2_wr level after 1 to 8 cycles, chosen
 * with $urandom. Unwritten words read as address ^ 32'h5a5a_0000.
 * Outputs change 1 ns after the rising edge.
 */

`timescale 1ns/1ps

module tb_l1d_mem (
    input  logic        clk,
    input  logic        lv2_rd,
    input  logic        lv2_wr,
    input  logic [31:0] lv2_addr,
    input  logic [31:0] lv2_wr_data,
    output logic        lv2_rd_valid,
    output logic [31:0] lv2_rd_data,
    output logic        lv2_wr_done
);

    logic [31:0] mem [logic [29:0]];
    int          wait_cnt;

    initial begin
        lv2_rd_valid = 1'b0;
        lv2_rd_data  = '0;
        lv2_wr_done  = 1'b0;
        wait_cnt     = 0;
        forever begin
            @(posedge clk);
            #1;
            lv2_rd_valid = 1'b0;
            lv2_wr_done  = 1'b0;
            if (lv2_rd || lv2_wr) begin
                // new level gets a fresh random latency
                if (wait_cnt == 0) begin
                    wait_cnt = $urandom_range(8, 1);
                end
                wait_cnt--;
                if (wait_cnt == 0 && lv2_wr) begin
                    mem[lv2_addr[31:2]] = lv2_wr_data;
                    lv2_wr_done = 1'b1;
                end else if (wait_cnt == 0) begin
                    if (mem.exists(lv2_addr[31:2])) begin
                        lv2_rd_data = mem[lv2_addr[31:2]];
                    end else begin
                        lv2_rd_data = {lv2_addr[31:2], 2'b00} ^ 32'h5a5a_0000;
                    end
                    lv2_rd_valid = 1'b1;
                end
            end
        end
    end

endmodule

//--- tb_l1d_top.sv
/*
 * Testbench for the L1 data cache. Keeps a shadow word memory and a
 * shadow cache with true LRU order, predicts hit, victim and write-back
 * for every access, and checks the DUT with concurrent assertions.
 * One access at a time, with one idle cycle after each response.
 */

`timescale 1ns/1ps

module tb_l1d_top;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        cpu_rd;
    logic        cpu_wr;
    logic [31:0] cpu_addr;
    logic [31:0] cpu_wdata;
    logic        busy;
    logic        rd_valid;
    logic [31:0] rd_data;
    logic        wr_done;
    logic        lv2_rd;
    logic        lv2_wr;
    logic [31:0] lv2_addr;
    logic [31:0] lv2_wr_data;
    logic        lv2_rd_valid;
    logic [31:0] lv2_rd_data;
    logic        lv2_wr_done;

    // predictions for the access in flight
    bit          exp_hit;
    bit          exp_is_wr;
    bit          exp_wb;
    bit          fill_seen;
    bit          wb_seen;
    logic [31:0] exp_wb_addr;
    logic [31:0] exp_wb_data;
    logic [31:0] exp_fill_addr;
    logic [31:0] exp_rd_data;

    // shadow cache, lru_order[s][0] is the most recent way
    logic [25:0] sh_tag   [16][4];
    bit          sh_valid [16][4];
    bit          sh_dirty [16][4];
    int          lru_order [16][4];
    logic [31:0] sh_mem [logic [29:0]];

    int errors = 0;
    int errors_mark = 0;
    int tests = 0;
    bit hung = 1'b0;

    always #10 clk = ~clk;

    l1d_top i_l1d_top (.*);

    tb_l1d_mem i_mem (.*);

    // ======================================================================
    // checks
    // ======================================================================
    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !busy && !rd_valid && !wr_done && !lv2_rd && !lv2_wr)
    else begin
        errors++;
        $display("outputs not all low during reset at %0t", $time);
    end

    a_rd_data: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid |-> rd_data == exp_rd_data)
    else begin
        errors++;
        $display("Error at %0t: rd_data expected %h actual %h",
                 $time, exp_rd_data, $sampled(rd_data));
    end

    a_done_kind: assert property (@(posedge clk) disable iff (!arst_n)
        (rd_valid || wr_done) |-> wr_done == exp_is_wr)
    else begin
        errors++;
        $display("Error at %0t: wr_done expected %b actual %b",
                 $time, exp_is_wr, $sampled(wr_done));
    end

    a_busy_rise: assert property (@(posedge clk) disable iff (!arst_n)
        (cpu_rd || cpu_wr) |=> busy)
    else begin
        errors++;
        $display("busy not raised on the edge that took the strobe at %0t", $time);
    end

    a_busy_fall: assert property (@(posedge clk) disable iff (!arst_n)
        (rd_valid || wr_done) |-> $fell(busy))
    else begin
        errors++;
        $display("busy did not fall together with the done pulse at %0t", $time);
    end

    a_fill_addr: assert property (@(posedge clk) disable iff (!arst_n)
        lv2_rd |-> lv2_addr == exp_fill_addr)
    else begin
        errors++;
        $display("Error at %0t: lv2_addr expected %h actual %h",
                 $time, exp_fill_addr, $sampled(lv2_addr));
    end

    a_wb_expected: assert property (@(posedge clk) disable iff (!arst_n)
        lv2_wr |-> exp_wb)
    else begin
        errors++;
        $display("write-back of a clean or absent line at %0t", $time);
    end

    a_wb_done: assert property (@(posedge clk) disable iff (!arst_n)
        (rd_valid || wr_done) && exp_wb |-> wb_seen)
    else begin
        errors++;
        $display("dirty victim replaced without a write-back at %0t", $time);
    end

    a_wb_addr: assert property (@(posedge clk) disable iff (!arst_n)
        lv2_wr |-> lv2_addr == exp_wb_addr)
    else begin
        errors++;
        $display("Error at %0t: lv2_addr expected %h actual %h",
                 $time, exp_wb_addr, $sampled(lv2_addr));
    end

    a_wb_data: assert property (@(posedge clk) disable iff (!arst_n)
        lv2_wr |-> lv2_wr_data == exp_wb_data)
    else begin
        errors++;
        $display("Error at %0t: lv2_wr_data expected %h actual %h",
                 $time, exp_wb_data, $sampled(lv2_wr_data));
    end

    a_hit_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        busy && exp_hit |-> !lv2_rd && !lv2_wr)
    else begin
        errors++;
        $display("lower-level access during a predicted hit at %0t", $time);
    end

    // strobe sampled at edge N, done pulse high after edge N+2
    a_hit_latency: assert property (@(posedge clk) disable iff (!arst_n)
        (cpu_rd || cpu_wr) && exp_hit |-> ##3 (rd_valid || wr_done))
    else begin
        errors++;
        $display("hit response not 2 cycles after the strobe at %0t", $time);
    end

    a_miss_filled: assert property (@(posedge clk) disable iff (!arst_n)
        (rd_valid || wr_done) && !exp_hit |-> fill_seen)
    else begin
        errors++;
        $display("predicted miss completed without a refill at %0t", $time);
    end

    a_lv2_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(lv2_rd && lv2_wr))
    else begin
        errors++;
        $display("lv2_rd and lv2_wr high together at %0t", $time);
    end

    // ======================================================================
    // shadow model and stimulus
    // ======================================================================
    function automatic logic [31:0] make_addr(int tag, int s);
        return {tag[25:0], s[3:0], 2'b00};
    endfunction

    function automatic logic [31:0] mem_word(logic [31:0] addr);
        if (sh_mem.exists(addr[31:2])) begin
            return sh_mem[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    // move a way to the front of its set's recency order
    function automatic void touch(int s, int way);
        int p;
        p = 0;
        for (int i = 0; i < 4; i++) begin
            if (lru_order[s][i] == way) begin
                p = i;
            end
        end
        for (int i = p; i > 0; i--) begin
            lru_order[s][i] = lru_order[s][i-1];
        end
        lru_order[s][0] = way;
    endfunction

    task automatic access(input bit is_wr, input logic [31:0] addr, input logic [31:0] wdata);
        int          s;
        int          way;
        int          cnt;
        logic [25:0] tag;
        if (!hung) begin
            s   = int'(addr[5:2]);
            tag = addr[31:6];
            way = -1;
            for (int w = 0; w < 4; w++) begin
                if (sh_valid[s][w] && sh_tag[s][w] == tag) begin
                    way = w;
                end
            end
            exp_hit = (way >= 0);
            exp_wb  = 1'b0;
            if (!exp_hit) begin
                // lowest invalid way, else the least recent one
                way = lru_order[s][3];
                for (int w = 3; w >= 0; w--) begin
                    if (!sh_valid[s][w]) begin
                        way = w;
                    end
                end
                exp_wb      = sh_valid[s][way] && sh_dirty[s][way];
                exp_wb_addr = {sh_tag[s][way], addr[5:2], 2'b00};
                exp_wb_data = mem_word(exp_wb_addr);
            end
            exp_is_wr     = is_wr;
            exp_fill_addr = {addr[31:2], 2'b00};
            exp_rd_data   = mem_word(addr);
            fill_seen     = 1'b0;
            wb_seen       = 1'b0;
            cpu_rd        = !is_wr;
            cpu_wr        = is_wr;
            cpu_addr      = addr;
            cpu_wdata     = wdata;
            @(posedge clk);
            #1;
            cpu_rd = 1'b0;
            cpu_wr = 1'b0;
            cnt    = 0;
            while (!(rd_valid || wr_done) && cnt < 100) begin
                @(posedge clk);
                #1;
                if (lv2_rd) begin
                    fill_seen = 1'b1;
                end
                if (lv2_wr) begin
                    wb_seen = 1'b1;
                end
                cnt++;
            end
            if (rd_valid || wr_done) begin
                sh_valid[s][way] = 1'b1;
                sh_tag[s][way]   = tag;
                if (is_wr) begin
                    sh_dirty[s][way]    = 1'b1;
                    sh_mem[addr[31:2]] = wdata;
                end else if (!exp_hit) begin
                    sh_dirty[s][way] = 1'b0;
                end
                touch(s, way);
                @(posedge clk);
                #1;
            end else begin
                errors++;
                hung = 1'b1;
                $display("timeout: no response to access of %h after %0d cycles", addr, cnt);
            end
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errors_mark);
        errors_mark = errors;
    endtask

    initial begin
        void'($urandom(32'he61a));
        arst_n    = 1'b0;
        cpu_rd    = 1'b0;
        cpu_wr    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        for (int s = 0; s < 16; s++) begin
            for (int w = 0; w < 4; w++) begin
                sh_valid[s][w]  = 1'b0;
                sh_dirty[s][w]  = 1'b0;
                sh_tag[s][w]    = '0;
                lru_order[s][w] = w;
            end
        end
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;

        access(1'b0, 32'h0000_0104, '0);
        end_test("reset and first read miss");
        access(1'b0, 32'h0000_0104, '0);
        end_test("read hit");

        access(1'b1, 32'h0000_0208, $urandom());
        access(1'b1, 32'h0000_0208, $urandom());
        access(1'b0, 32'h0000_0208, '0);
        end_test("write miss, write hit, read back");

        // fill set 3, fifth tag evicts, then a known touch order
        for (int t = 1; t <= 5; t++) begin
            access(1'b1, make_addr(t, 3), $urandom());
        end
        access(1'b0, make_addr(3, 3), '0);
        access(1'b0, make_addr(5, 3), '0);
        access(1'b0, make_addr(2, 3), '0);
        access(1'b0, make_addr(4, 3), '0);
        access(1'b1, make_addr(6, 3), $urandom());
        end_test("LRU victim write-back");

        access(1'b0, make_addr(1, 3), '0);
        access(1'b0, make_addr(3, 3), '0);
        end_test("read of evicted lines");

        repeat (200) begin
            access(($urandom() % 2) == 1,
                   make_addr(int'($urandom_range(7, 0)), 5 + int'($urandom_range(2, 0))),
                   $urandom());
        end
        end_test("random mixed traffic");

        $display("tests run %0d, failed checks %0d", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- vlog.f
l1d_pkg.sv
l1d_lookup.sv
l1d_lru.sv
l1d_data_array.sv
l1d_ctrl.sv
l1d_top.sv
tb_l1d_mem.sv
tb_l1d_top.sv

//--- Makefile
# Verilator build and run for the L1 data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_l1d_top
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
